//--- cadr_uinst_pkg.sv
// CADR microinstruction package: field layouts, ALU and jump codes, control-word union
package cadr_uinst_pkg;

   localparam int UINST_W = 48;                    // Control word, no parity
   localparam int KIND_W  = 2;
   localparam int ALUF_W  = 4;
   localparam int JC_W    = 2;

   // Kind codes in the top bits
   localparam logic [KIND_W-1:0] KIND_ALU  = 2'd0; // All-zero word is ALU SETZ
   localparam logic [KIND_W-1:0] KIND_JUMP = 2'd1;
   localparam logic [KIND_W-1:0] KIND_DISP = 2'd2; // Executes as no-op
   localparam logic [KIND_W-1:0] KIND_BYTE = 2'd3; // Executes as no-op

   // ALU functions, other codes give zero
   localparam logic [ALUF_W-1:0] ALU_SETZ = 4'd0;
   localparam logic [ALUF_W-1:0] ALU_A    = 4'd1;
   localparam logic [ALUF_W-1:0] ALU_M    = 4'd2;
   localparam logic [ALUF_W-1:0] ALU_ADD  = 4'd3;  // A+M+cin
   localparam logic [ALUF_W-1:0] ALU_SUB  = 4'd4;  // A-M-1+cin
   localparam logic [ALUF_W-1:0] ALU_AND  = 4'd5;
   localparam logic [ALUF_W-1:0] ALU_OR   = 4'd6;
   localparam logic [ALUF_W-1:0] ALU_XOR  = 4'd7;
   localparam logic [ALUF_W-1:0] ALU_SETO = 4'd8;

   // Jump conditions
   localparam logic [JC_W-1:0] JC_ALWAYS = 2'd0;
   localparam logic [JC_W-1:0] JC_EQ     = 2'd1;   // A equals M
   localparam logic [JC_W-1:0] JC_LT     = 2'd2;   // A below M, signed
   localparam logic [JC_W-1:0] JC_NEVER  = 2'd3;

   // kind on top, A/M addresses at the bottom, same in both forms
   typedef struct packed {
      logic [KIND_W-1:0] kind;
      logic              dest_a;                   // Write A[dest_adr]
      logic              dest_m;                   // Write M and the matching A word
      logic [5:0]        dest_adr;
      logic [ALUF_W-1:0] aluf;
      logic              cin;
      logic [21:0]       padding;
      logic [5:0]        a_adr;
      logic [4:0]        m_adr;
   } uinst_alu_t;

   typedef struct packed {
      logic [KIND_W-1:0] kind;
      logic [JC_W-1:0]   cond;
      logic              invert;                   // Flip the selected condition
      logic              halt;                     // Clear run, taken or not
      logic [13:0]       jump_adr;
      logic [16:0]       padding;
      logic [5:0]        a_adr;
      logic [4:0]        m_adr;
   } uinst_jump_t;

   typedef union packed {
      uinst_alu_t  alu;
      uinst_jump_t jmp;
   } uinst_u;

endpackage

//--- cadr_arch_pkg.sv
// CADR architecture package: machine widths, spy register map, cycle and debug control types
package cadr_arch_pkg;

   //////////////////////////////////////////////////
   // Machine widths

   localparam int WORD_W  = 32;                    // Data word
   localparam int PC_W    = 14;                    // Microprogram counter
   localparam int IRAM_AW = 8;                     // Low PC bits index IRAM
   localparam int AMEM_AW = 6;                     // 64 A words
   localparam int MMEM_AW = 5;                     // 32 M words
   localparam int SPY_W   = 16;                    // Spy data path
   localparam int EADR_W  = 5;                     // Spy register address

   //////////////////////////////////////////////////
   // Spy register map

   // Write side
   localparam logic [EADR_W-1:0] SPY_WR_IRL  = 5'd0;  // Debug word bits 15:0
   localparam logic [EADR_W-1:0] SPY_WR_IRM  = 5'd1;  // Debug word bits 31:16
   localparam logic [EADR_W-1:0] SPY_WR_IRH  = 5'd2;  // Debug word bits 47:32
   localparam logic [EADR_W-1:0] SPY_WR_IRAM = 5'd3;  // Data is IRAM address, commits word
   localparam logic [EADR_W-1:0] SPY_WR_MODE = 5'd4;  // Bit 0 sets or clears run
   localparam logic [EADR_W-1:0] SPY_WR_PC   = 5'd5;
   localparam logic [EADR_W-1:0] SPY_WR_AADR = 5'd6;  // A address for AL/AH readback

   // Read side, unmapped codes read zero
   localparam logic [EADR_W-1:0] SPY_RD_PC     = 5'd0;
   localparam logic [EADR_W-1:0] SPY_RD_STATUS = 5'd1;  // Bit 0 is run
   localparam logic [EADR_W-1:0] SPY_RD_OBL    = 5'd2;
   localparam logic [EADR_W-1:0] SPY_RD_OBH    = 5'd3;
   localparam logic [EADR_W-1:0] SPY_RD_AL     = 5'd4;
   localparam logic [EADR_W-1:0] SPY_RD_AH     = 5'd5;

   //////////////////////////////////////////////////
   // Shared types

   // One-hot major cycle plus run mode, all zero cycle bits is RESET
   typedef struct packed {
      logic decode;                                // A/M read addresses applied
      logic read;                                  // A/M data valid
      logic alu;                                   // L latch loads
      logic write;                                 // Writeback and PC update
      logic fetch;                                 // IR loads from IRAM
      logic machrun;                               // Run mode
   } cycle_t;

   typedef struct packed {
      logic                                 iram_we;    // Commit strobe
      logic [IRAM_AW-1:0]                   iram_adr;
      logic [cadr_uinst_pkg::UINST_W-1:0]   iram_word;  // Assembled from three loads
      logic                                 pc_load;    // PC load strobe
      logic [PC_W-1:0]                      pc_value;
      logic [AMEM_AW-1:0]                   spy_a_adr;  // A read address while halted
   } dbg_ctl_t;

endpackage

//--- cadr_alu.sv
// CADR ALU: 32-bit function unit with carry in and compare outputs for jumps
`timescale 1ns/1ps

module cadr_alu (
   input  logic [cadr_arch_pkg::WORD_W-1:0]  a,
   input  logic [cadr_arch_pkg::WORD_W-1:0]  m,
   input  logic [cadr_uinst_pkg::ALUF_W-1:0] aluf,
   input  logic                              cin,
   output logic [cadr_arch_pkg::WORD_W-1:0]  result,
   output logic                              a_eq_m,
   output logic                              a_lt_m
);

   localparam int W = cadr_arch_pkg::WORD_W;

   logic [W-1:0] carry;                            // Carry in widened to the word

   assign carry = W'(cin);

   always_comb begin
      case (aluf)
         cadr_uinst_pkg::ALU_SETZ: result = '0;
         cadr_uinst_pkg::ALU_A:    result = a;
         cadr_uinst_pkg::ALU_M:    result = m;
         cadr_uinst_pkg::ALU_ADD:  result = a + m + carry;
         cadr_uinst_pkg::ALU_SUB:  result = a - m - 1'b1 + carry; // cin=1 gives A-M
         cadr_uinst_pkg::ALU_AND:  result = a & m;
         cadr_uinst_pkg::ALU_OR:   result = a | m;
         cadr_uinst_pkg::ALU_XOR:  result = a ^ m;
         cadr_uinst_pkg::ALU_SETO: result = '1;
         default:                  result = '0;    // Unused codes
      endcase
   end

   // Compares for the jump condition
   assign a_eq_m = a == m;
   assign a_lt_m = $signed(a) < $signed(m);

endmodule

//--- cadr_sequencer.sv
// CADR sequencer: one-hot major-cycle state machine and run/halt mode register
`timescale 1ns/1ps

module cadr_sequencer (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   run_set,        // Spy mode write, bit 0 high
   input  logic                   run_clr,        // Spy mode write, bit 0 low
   input  cadr_uinst_pkg::uinst_u ir,
   output cadr_arch_pkg::cycle_t  cycle
);

   logic [4:0] state;                              // {decode, read, alu, write, fetch}
   logic [4:0] state_next;
   logic       machrun;
   logic       halt_hit;

   // Halting JUMP retires in WRITE
   assign halt_hit = state[1] && ir.jmp.kind == cadr_uinst_pkg::KIND_JUMP && ir.jmp.halt;

   // Ring of five, DECODE waits for run, RESET falls into DECODE
   assign state_next = {state[0] | (state[4] & ~machrun) | (state == 5'b0),
                        state[4] & machrun,        // READ
                        state[3],                  // ALU
                        state[2],                  // WRITE
                        state[1]};                 // FETCH

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= 5'b0;                            // RESET
      end else begin
         state <= state_next;
      end
   end

   // Run mode, halt wins over a late spy set
   always_ff @(posedge clk) begin
      if (reset) begin
         machrun <= 1'b0;
      end else if (halt_hit || run_clr) begin
         machrun <= 1'b0;
      end else if (run_set) begin
         machrun <= 1'b1;
      end
   end

   assign cycle = {state, machrun};                // Same order as cycle_t

   // Only the single cycle leaving reset may show no state bit
   a_state_onehot: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> $onehot(state));

endmodule

//--- cadr_debug_port.sv
// CADR spy port: register decode, debug control-word assembly and readout mux
`timescale 1ns/1ps

module cadr_debug_port (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 dbread,
   input  logic                                 dbwrite,
   input  logic [cadr_arch_pkg::EADR_W-1:0]     eadr,
   input  logic [cadr_arch_pkg::SPY_W-1:0]      spy_in,
   output logic [cadr_arch_pkg::SPY_W-1:0]      spy_out,
   input  logic [cadr_arch_pkg::PC_W-1:0]       pc,
   input  cadr_arch_pkg::cycle_t                cycle,
   input  logic [cadr_arch_pkg::WORD_W-1:0]     ob,
   input  logic [cadr_arch_pkg::WORD_W-1:0]     spy_a_data,
   output cadr_arch_pkg::dbg_ctl_t              dbg,
   output logic                                 run_set,
   output logic                                 run_clr
);

   localparam int SW = cadr_arch_pkg::SPY_W;

   logic [cadr_uinst_pkg::UINST_W-1:0] dbg_word;   // Debug IR being assembled
   logic [cadr_arch_pkg::AMEM_AW-1:0]  a_adr_q;    // Held A readback address

   //////////////////////////////////////////////////
   // Write side

   always_ff @(posedge clk) begin
      if (dbwrite) begin
         case (eadr)
            cadr_arch_pkg::SPY_WR_IRL: dbg_word[SW-1:0]      <= spy_in;
            cadr_arch_pkg::SPY_WR_IRM: dbg_word[2*SW-1:SW]   <= spy_in;
            cadr_arch_pkg::SPY_WR_IRH: dbg_word[3*SW-1:2*SW] <= spy_in;
            default: ;                             // Other codes leave the word alone
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         a_adr_q <= '0;
      end else if (dbwrite && eadr == cadr_arch_pkg::SPY_WR_AADR) begin
         a_adr_q <= spy_in[cadr_arch_pkg::AMEM_AW-1:0];
      end
   end

   // Strobes act at the next edge in the consumer
   always_comb begin
      dbg.iram_we   = dbwrite && eadr == cadr_arch_pkg::SPY_WR_IRAM;
      dbg.iram_adr  = spy_in[cadr_arch_pkg::IRAM_AW-1:0];
      dbg.iram_word = dbg_word;
      dbg.pc_load   = dbwrite && eadr == cadr_arch_pkg::SPY_WR_PC;
      dbg.pc_value  = spy_in[cadr_arch_pkg::PC_W-1:0];
      dbg.spy_a_adr = a_adr_q;
   end

   assign run_set = dbwrite && eadr == cadr_arch_pkg::SPY_WR_MODE && spy_in[0];
   assign run_clr = dbwrite && eadr == cadr_arch_pkg::SPY_WR_MODE && !spy_in[0];

   //////////////////////////////////////////////////
   // Read side

   always_comb begin
      spy_out = '0;
      if (dbread) begin
         case (eadr)
            cadr_arch_pkg::SPY_RD_PC:     spy_out = SW'(pc);
            cadr_arch_pkg::SPY_RD_STATUS: spy_out = SW'(cycle.machrun);
            cadr_arch_pkg::SPY_RD_OBL:    spy_out = ob[SW-1:0];
            cadr_arch_pkg::SPY_RD_OBH:    spy_out = ob[2*SW-1:SW];
            cadr_arch_pkg::SPY_RD_AL:     spy_out = spy_a_data[SW-1:0];
            cadr_arch_pkg::SPY_RD_AH:     spy_out = spy_a_data[2*SW-1:SW];
            default:                      spy_out = '0;
         endcase
      end
   end

   // Control store may only be touched while the sequencer is halted
   a_no_load_running: assert property (@(posedge clk) disable iff (reset)
      (dbg.iram_we || dbg.pc_load) |-> !cycle.machrun);

endmodule

//--- cadr_control_store.sv
// CADR control store: IRAM, instruction register and PC with next-PC selection
`timescale 1ns/1ps

module cadr_control_store (
   input  logic                            clk,
   input  logic                            reset,
   input  cadr_arch_pkg::cycle_t           cycle,
   input  cadr_arch_pkg::dbg_ctl_t         dbg,
   input  logic                            jcond,  // Selected jump condition holds
   output cadr_uinst_pkg::uinst_u          ir,
   output logic [cadr_arch_pkg::PC_W-1:0]  pc
);

   logic [cadr_uinst_pkg::UINST_W-1:0] iram [2**cadr_arch_pkg::IRAM_AW];
   logic [cadr_arch_pkg::PC_W-1:0]     pc_next;
   logic                               ir_reload; // IR refill after spy PC load
   logic                               jump_taken;

   //////////////////////////////////////////////////
   // IRAM, written from the spy port only

   always_ff @(posedge clk) begin
      if (dbg.iram_we) begin
         iram[dbg.iram_adr] <= dbg.iram_word;
      end
   end

   //////////////////////////////////////////////////
   // PC

   assign jump_taken = ir.jmp.kind == cadr_uinst_pkg::KIND_JUMP && jcond;
   assign pc_next    = jump_taken ? ir.jmp.jump_adr : pc + 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (dbg.pc_load) begin
         pc <= dbg.pc_value;                       // Spy load, halted only
      end else if (cycle.write) begin
         pc <= pc_next;
      end
   end

   //////////////////////////////////////////////////
   // Instruction register

   always_ff @(posedge clk) begin
      if (reset) begin
         ir_reload <= 1'b0;
      end else begin
         ir_reload <= dbg.pc_load;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ir <= '0;                                 // ALU SETZ, no destination
      end else if (cycle.fetch || ir_reload) begin
         ir <= iram[pc[cadr_arch_pkg::IRAM_AW-1:0]];
      end
   end

endmodule

//--- cadr_datapath.sv
// CADR datapath with A and M scratchpads, ALU, L latch, writeback and jump condition
`timescale 1ns/1ps

module cadr_datapath (
   input  logic                              clk,
   input  logic                              reset,
   input  cadr_arch_pkg::cycle_t             cycle,
   input  cadr_uinst_pkg::uinst_u            ir,
   input  cadr_arch_pkg::dbg_ctl_t           dbg,
   output logic [cadr_arch_pkg::WORD_W-1:0]  ob,
   output logic                              jcond,
   output logic [cadr_arch_pkg::WORD_W-1:0]  spy_a_data
);

   localparam int W = cadr_arch_pkg::WORD_W;

   logic [W-1:0] amem [2**cadr_arch_pkg::AMEM_AW];
   logic [W-1:0] mmem [2**cadr_arch_pkg::MMEM_AW];
   logic [W-1:0] a_q, m_q;                         // Registered read data
   logic [W-1:0] l_q;                              // L latch
   logic [cadr_arch_pkg::AMEM_AW-1:0] a_rd_adr;
   logic         a_eq_m, a_lt_m, cond_hit;
   logic         is_alu, a_we, m_we;

   //////////////////////////////////////////////////
   // Scratchpad reads

   assign a_rd_adr = cycle.machrun ? ir.alu.a_adr : dbg.spy_a_adr; // Spy owns A when halted

   always_ff @(posedge clk) begin
      if (cycle.decode) begin
         a_q <= amem[a_rd_adr];
         m_q <= mmem[ir.alu.m_adr];
      end
   end

   assign spy_a_data = a_q;

   cadr_alu i_alu (
      .a      (a_q),
      .m      (m_q),
      .aluf   (ir.alu.aluf),
      .cin    (ir.alu.cin),
      .result (ob),
      .a_eq_m (a_eq_m),
      .a_lt_m (a_lt_m)
   );

   always_ff @(posedge clk) begin
      if (cycle.alu) begin
         l_q <= ob;
      end
   end

   //////////////////////////////////////////////////
   // Writeback where an M destination also writes A

   assign is_alu = ir.alu.kind == cadr_uinst_pkg::KIND_ALU;
   assign a_we   = cycle.write && is_alu && (ir.alu.dest_a || ir.alu.dest_m);
   assign m_we   = cycle.write && is_alu && ir.alu.dest_m;

   always_ff @(posedge clk) begin
      if (a_we) amem[ir.alu.dest_adr] <= l_q;
      if (m_we) mmem[ir.alu.dest_adr[cadr_arch_pkg::MMEM_AW-1:0]] <= l_q;
   end

   // Jump condition held stable from READ through WRITE
   always_comb begin
      case (ir.jmp.cond)
         cadr_uinst_pkg::JC_ALWAYS: cond_hit = 1'b1;
         cadr_uinst_pkg::JC_EQ:     cond_hit = a_eq_m;
         cadr_uinst_pkg::JC_LT:     cond_hit = a_lt_m;
         default:                   cond_hit = 1'b0; // JC_NEVER
      endcase
   end

   assign jcond = cond_hit ^ ir.jmp.invert;

   // Writeback follows the ALU cycle of the same instruction
   a_write_after_alu: assert property (@(posedge clk) disable iff (reset)
      (a_we || m_we) |-> $past(cycle.alu) && $stable(ir));

endmodule

//--- cadr_top.sv
// CADR processor core: sequencer, spy port, control store and datapath
`timescale 1ns/1ps

module cadr_top (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             dbread,   // Spy read enable
   input  logic                             dbwrite,  // Spy write pulse
   input  logic [cadr_arch_pkg::EADR_W-1:0] eadr,
   input  logic [cadr_arch_pkg::SPY_W-1:0]  spy_in,
   output logic [cadr_arch_pkg::SPY_W-1:0]  spy_out
);

   cadr_arch_pkg::cycle_t             cycle;
   cadr_arch_pkg::dbg_ctl_t           dbg;
   cadr_uinst_pkg::uinst_u            ir;
   logic [cadr_arch_pkg::PC_W-1:0]    pc;
   logic [cadr_arch_pkg::WORD_W-1:0]  ob;
   logic [cadr_arch_pkg::WORD_W-1:0]  spy_a_data;
   logic                              jcond;
   logic                              run_set, run_clr;

   //////////////////////////////////////////////////
   // Control

   cadr_sequencer i_sequencer (
      .clk     (clk),
      .reset   (reset),
      .run_set (run_set),
      .run_clr (run_clr),
      .ir      (ir),
      .cycle   (cycle)
   );

   cadr_debug_port i_debug_port (
      .clk        (clk),
      .reset      (reset),
      .dbread     (dbread),
      .dbwrite    (dbwrite),
      .eadr       (eadr),
      .spy_in     (spy_in),
      .spy_out    (spy_out),
      .pc         (pc),
      .cycle      (cycle),
      .ob         (ob),
      .spy_a_data (spy_a_data),
      .dbg        (dbg),
      .run_set    (run_set),
      .run_clr    (run_clr)
   );

   cadr_control_store i_control_store (
      .clk   (clk),
      .reset (reset),
      .cycle (cycle),
      .dbg   (dbg),
      .jcond (jcond),
      .ir    (ir),
      .pc    (pc)
   );

   //////////////////////////////////////////////////
   // Data

   cadr_datapath i_datapath (
      .clk        (clk),
      .reset      (reset),
      .cycle      (cycle),
      .ir         (ir),
      .dbg        (dbg),
      .ob         (ob),
      .jcond      (jcond),
      .spy_a_data (spy_a_data)
   );

endmodule

//--- tb_cadr.sv
// CADR testbench loading microcode over the spy port and checking runs against an emulator
`timescale 1ns/1ps

module tb_cadr;

   localparam int N_RAND    = 40;                 // Random ALU ops in the straight-line program
   localparam int MAX_LIMIT = 16;                 // Loop limit bound
   localparam int N_HALT    = 4;                  // Single halting jump trials
   localparam int N_RUNS    = 4 + N_HALT;
   localparam int N_LOADED  = (65 + N_RAND) + (6 + MAX_LIMIT) + 2 * 5 + N_HALT + 1;
   localparam int N_EXEC    = (65 + N_RAND) + (4 + 3 * MAX_LIMIT) + 2 * 5 + N_HALT;
   localparam int DBG_CYC   = 8 * N_LOADED + N_RUNS * (64 * 10 + 24) + 64;
   localparam int BUDGET_NS = 2 * (N_EXEC * 5 + DBG_CYC) * 4;  // Doubled at 4 ns per cycle

   logic                                clk;
   logic                                reset;
   logic                                dbread;
   logic                                dbwrite;
   logic [cadr_arch_pkg::EADR_W-1:0]    eadr;
   logic [cadr_arch_pkg::SPY_W-1:0]     spy_in;
   logic [cadr_arch_pkg::SPY_W-1:0]     spy_out;

   logic [cadr_uinst_pkg::UINST_W-1:0]  prog [256];  // Mirror of IRAM
   logic [31:0]                         ref_a [64];  // Emulator A memory
   logic [31:0]                         ref_m [32];  // Emulator M memory
   logic [31:0]                         rng;
   int                                  errors;
   int                                  tests;
   int                                  failed;

   cadr_top i_dut (
      .clk     (clk),
      .reset   (reset),
      .dbread  (dbread),
      .dbwrite (dbwrite),
      .eadr    (eadr),
      .spy_in  (spy_in),
      .spy_out (spy_out)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;                          // 4 ns period

   // Budget from program lengths and spy traffic
   initial begin
      #(BUDGET_NS);
      $display("Watchdog expired after %0d ns, a run or spy poll never finished", BUDGET_NS);
      $display("Simulation FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus helpers

   function automatic logic [31:0] xorshift32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [47:0] alu_word(input logic da, input logic dm,
                                            input logic [5:0] dadr, input logic [3:0] f,
                                            input logic c, input logic [5:0] aa,
                                            input logic [4:0] ma);
      cadr_uinst_pkg::uinst_u u;
      u            = '0;
      u.alu.kind   = cadr_uinst_pkg::KIND_ALU;
      u.alu.dest_a = da;
      u.alu.dest_m = dm;                          // Also lands in A[dadr]
      u.alu.dest_adr = dadr;
      u.alu.aluf   = f;
      u.alu.cin    = c;
      u.alu.a_adr  = aa;
      u.alu.m_adr  = ma;
      return u;
   endfunction

   function automatic logic [47:0] jump_word(input logic [1:0] cond, input logic inv,
                                             input logic hlt, input logic [13:0] tgt,
                                             input logic [5:0] aa, input logic [4:0] ma);
      cadr_uinst_pkg::uinst_u u;
      u              = '0;
      u.jmp.kind     = cadr_uinst_pkg::KIND_JUMP;
      u.jmp.cond     = cond;
      u.jmp.invert   = inv;
      u.jmp.halt     = hlt;
      u.jmp.jump_adr = tgt;
      u.jmp.a_adr    = aa;
      u.jmp.m_adr    = ma;
      return u;
   endfunction

   task automatic spy_write(input logic [4:0] adr, input logic [15:0] data);
      @(posedge clk);
      #1;
      dbread  = 1'b0;
      dbwrite = 1'b1;                             // One-cycle strobe
      eadr    = adr;
      spy_in  = data;
      @(posedge clk);
      #1;
      dbwrite = 1'b0;
   endtask

   task automatic spy_read(input logic [4:0] adr, output logic [15:0] data);
      @(posedge clk);
      #1;
      dbread = 1'b1;
      eadr   = adr;
      @(negedge clk);
      data   = spy_out;                           // Combinational path settled mid-cycle
   endtask

   task automatic load_uinst(input int adr, input logic [47:0] w);
      prog[adr] = w;
      spy_write(cadr_arch_pkg::SPY_WR_IRL, w[15:0]);
      spy_write(cadr_arch_pkg::SPY_WR_IRM, w[31:16]);
      spy_write(cadr_arch_pkg::SPY_WR_IRH, w[47:32]);
      spy_write(cadr_arch_pkg::SPY_WR_IRAM, 16'(adr));  // Commit
   endtask

   task automatic read_a(input int adr, output logic [31:0] data);
      logic [15:0] lo;
      logic [15:0] hi;
      spy_write(cadr_arch_pkg::SPY_WR_AADR, 16'(adr));
      repeat (2) @(posedge clk);                  // Address reg then A read reg
      spy_read(cadr_arch_pkg::SPY_RD_AL, lo);
      spy_read(cadr_arch_pkg::SPY_RD_AH, hi);
      data = {hi, lo};
   endtask

   //////////////////////////////////////////////////
   // Reference model

   function automatic logic [31:0] alu_ref(input logic [3:0] f, input logic c,
                                           input logic [31:0] a, input logic [31:0] m);
      case (f)
         cadr_uinst_pkg::ALU_A:    return a;
         cadr_uinst_pkg::ALU_M:    return m;
         cadr_uinst_pkg::ALU_ADD:  return a + m + 32'(c);
         cadr_uinst_pkg::ALU_SUB:  return a - m - 32'd1 + 32'(c);
         cadr_uinst_pkg::ALU_AND:  return a & m;
         cadr_uinst_pkg::ALU_OR:   return a | m;
         cadr_uinst_pkg::ALU_XOR:  return a ^ m;
         cadr_uinst_pkg::ALU_SETO: return 32'hffff_ffff;
         default:                  return 32'h0;  // SETZ and unused codes
      endcase
   endfunction

   // Runs prog from PC 0 until a halting jump and updates ref_a/ref_m
   function automatic int emulate(output logic [13:0] fin_pc, output logic fin_run);
      cadr_uinst_pkg::uinst_u u;
      logic [31:0] a;
      logic [31:0] m;
      logic [31:0] r;
      logic [13:0] pc;
      logic        run;
      logic        hit;
      int          steps;
      pc    = '0;
      run   = 1'b1;
      steps = 0;
      while (run && steps < 100000) begin
         u = prog[pc[7:0]];                       // Low 8 PC bits index IRAM
         a = ref_a[u.alu.a_adr];
         m = ref_m[u.alu.m_adr];
         steps++;
         if (u.alu.kind == cadr_uinst_pkg::KIND_ALU) begin
            r = alu_ref(u.alu.aluf, u.alu.cin, a, m);
            if (u.alu.dest_a || u.alu.dest_m) begin
               ref_a[u.alu.dest_adr] = r;
            end
            if (u.alu.dest_m) begin
               ref_m[u.alu.dest_adr[4:0]] = r;
            end
            pc = pc + 14'd1;
         end else if (u.jmp.kind == cadr_uinst_pkg::KIND_JUMP) begin
            case (u.jmp.cond)
               cadr_uinst_pkg::JC_ALWAYS: hit = 1'b1;
               cadr_uinst_pkg::JC_EQ:     hit = a == m;
               cadr_uinst_pkg::JC_LT:     hit = $signed(a) < $signed(m);
               default:                   hit = 1'b0;
            endcase
            pc = (hit ^ u.jmp.invert) ? u.jmp.jump_adr : pc + 14'd1;
            if (u.jmp.halt) begin
               run = 1'b0;                        // Halts taken or not
            end
         end else begin
            pc = pc + 14'd1;                      // Dispatch and byte kinds
         end
      end
      fin_pc  = pc;
      fin_run = run;
      return steps;
   endfunction

   //////////////////////////////////////////////////
   // Run and compare

   task automatic run_and_check();
      logic [13:0] exp_pc;
      logic        exp_run;
      logic [15:0] d;
      logic [31:0] got;
      int          steps;
      steps = emulate(exp_pc, exp_run);
      if (exp_run) begin
         $display("Reference emulator ran %0d steps without reaching a halt", steps);
         errors++;
      end
      spy_write(cadr_arch_pkg::SPY_WR_PC, 16'h0);
      spy_write(cadr_arch_pkg::SPY_WR_MODE, 16'h1);
      d = 16'h1;
      while (d[0] !== 1'b0) begin                 // Poll run bit until halted
         spy_read(cadr_arch_pkg::SPY_RD_STATUS, d);
      end
      spy_read(cadr_arch_pkg::SPY_RD_PC, d);
      if (d !== {2'b00, exp_pc}) begin
         $display("ERR pc got %h exp %h", d, {2'b00, exp_pc});
         errors++;
      end
      for (int k = 0; k < 64; k++) begin
         read_a(k, got);
         if (got !== ref_a[k]) begin
            $display("ERR a_mem[%0d] got %h exp %h", k, got, ref_a[k]);
            errors++;
         end
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("test %-12s ok", name);
      end else begin
         failed++;
         $display("test %-12s failed with %0d errors", name, errors - err_before);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial begin
      cadr_uinst_pkg::uinst_u u;
      logic [15:0] d;
      logic [31:0] v;
      logic [31:0] w;
      logic [31:0] exp_ob;
      logic [4:0]  k;
      logic [4:0]  z;
      logic [4:0]  p;
      int          n;
      int          err0;
      rng     = 32'hede1f45d;
      errors  = 0;
      tests   = 0;
      failed  = 0;
      reset   = 1'b1;
      dbread  = 1'b0;
      dbwrite = 1'b0;
      eadr    = '0;
      spy_in  = '0;
      for (int i = 0; i < 64; i++) begin
         ref_a[i] = '0;
      end
      for (int i = 0; i < 32; i++) begin
         ref_m[i] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      // Idle state after reset
      err0 = errors;
      spy_read(cadr_arch_pkg::SPY_RD_STATUS, d);
      if (d !== 16'h0) begin
         $display("ERR status got %h exp %h", d, 16'h0);
         errors++;
      end
      spy_read(cadr_arch_pkg::SPY_RD_PC, d);
      if (d !== 16'h0) begin
         $display("ERR pc got %h exp %h", d, 16'h0);
         errors++;
      end
      report_test("reset_state", err0);

      // PC load and readback
      err0 = errors;
      v = xorshift32();
      spy_write(cadr_arch_pkg::SPY_WR_PC, v[15:0]);
      spy_read(cadr_arch_pkg::SPY_RD_PC, d);
      if (d !== {2'b00, v[13:0]}) begin
         $display("ERR pc got %h exp %h", d, {2'b00, v[13:0]});
         errors++;
      end
      report_test("pc_write", err0);

      // Clear all of A and M before random ALU ops
      err0 = errors;
      for (int i = 0; i < 64; i++) begin
         load_uinst(i, alu_word(i >= 32, i < 32, 6'(i), cadr_uinst_pkg::ALU_SETZ, 0, 0, 0));
      end
      for (int i = 0; i < N_RAND; i++) begin
         v = xorshift32();
         u = alu_word(v[0], v[1], v[7:2], v[11:8], v[12], v[18:13], v[23:19]);
         if (v[26:24] == 3'd0) begin
            u.alu.kind = v[27] ? cadr_uinst_pkg::KIND_DISP : cadr_uinst_pkg::KIND_BYTE;
         end
         load_uinst(64 + i, u);
      end
      v = xorshift32();
      load_uinst(64 + N_RAND, jump_word(cadr_uinst_pkg::JC_NEVER, 0, 1, v[13:0], 0, 0));
      run_and_check();
      report_test("alu_random", err0);

      // Count A[40] up to limit M[3]
      err0 = errors;
      v = xorshift32();
      n = 1 + int'(v[3:0]);
      load_uinst(0, alu_word(1, 0, 6'd40, cadr_uinst_pkg::ALU_SETZ, 0, 0, 0));
      load_uinst(1, alu_word(0, 1, 6'd3, cadr_uinst_pkg::ALU_SETZ, 0, 0, 0));
      load_uinst(2, alu_word(0, 1, 6'd4, cadr_uinst_pkg::ALU_SETZ, 0, 0, 0));
      for (int i = 0; i < n; i++) begin
         load_uinst(3 + i, alu_word(0, 1, 6'd3, cadr_uinst_pkg::ALU_ADD, 1, 6'd3, 5'd4));
      end
      load_uinst(3 + n, alu_word(1, 0, 6'd40, cadr_uinst_pkg::ALU_ADD, 1, 6'd40, 5'd4));
      load_uinst(4 + n, jump_word(cadr_uinst_pkg::JC_EQ, 1, 0, 14'(3 + n), 6'd40, 5'd3));
      load_uinst(5 + n, jump_word(cadr_uinst_pkg::JC_NEVER, 0, 1, v[17:4], 0, 0));
      run_and_check();
      report_test("count_loop", err0);

      // Signed compare on values built by SUB, first taken and then not
      err0 = errors;
      for (int t = 0; t < 2; t++) begin
         v = xorshift32();
         k = v[4:0];
         z = k + 5'd1;
         p = k + 5'd2;
         load_uinst(0, alu_word(0, 1, {1'b0, k}, cadr_uinst_pkg::ALU_SETO, 0, 0, 0));
         load_uinst(1, alu_word(0, 1, {1'b0, z}, cadr_uinst_pkg::ALU_SETZ, 0, 0, 0));
         load_uinst(2, alu_word(0, 1, {1'b0, p}, cadr_uinst_pkg::ALU_ADD, 1, {1'b0, z}, z));
         load_uinst(3, alu_word(1, 0, 6'd50, cadr_uinst_pkg::ALU_SUB, 0, {1'b0, z}, p));
         if (t == 0) begin
            load_uinst(4, jump_word(cadr_uinst_pkg::JC_LT, 0, 1, v[18:5], 6'd50, z));
         end else begin
            load_uinst(4, jump_word(cadr_uinst_pkg::JC_LT, 0, 1, v[18:5], {1'b0, z}, k));
         end
         run_and_check();
      end
      report_test("signed_lt", err0);

      // Lone halting jump with a random condition
      err0 = errors;
      for (int t = 0; t < N_HALT; t++) begin
         v = xorshift32();
         load_uinst(0, jump_word(v[1:0], v[2], 1, v[16:3], v[22:17], v[27:23]));
         run_and_check();
      end
      report_test("halt_jump", err0);

      // Halted output bus shows the spy A word XOR an M word
      err0 = errors;
      v = xorshift32();
      load_uinst(0, alu_word(0, 0, 6'd0, cadr_uinst_pkg::ALU_XOR, 0, 6'd0, v[10:6]));
      spy_write(cadr_arch_pkg::SPY_WR_PC, 16'h0);   // IR reloads from address 0
      read_a(int'(v[5:0]), w);
      exp_ob = alu_ref(cadr_uinst_pkg::ALU_XOR, 1'b0, ref_a[v[5:0]], ref_m[v[10:6]]);
      spy_read(cadr_arch_pkg::SPY_RD_OBL, d);
      if (d !== exp_ob[15:0]) begin
         $display("ERR ob_low got %h exp %h", d, exp_ob[15:0]);
         errors++;
      end
      spy_read(cadr_arch_pkg::SPY_RD_OBH, d);
      if (d !== exp_ob[31:16]) begin
         $display("ERR ob_high got %h exp %h", d, exp_ob[31:16]);
         errors++;
      end
      report_test("ob_readout", err0);

      $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
cadr_uinst_pkg.sv
cadr_arch_pkg.sv
cadr_alu.sv
cadr_sequencer.sv
cadr_debug_port.sv
cadr_control_store.sv
cadr_datapath.sv
cadr_top.sv
tb_cadr.sv

//--- Bender.yml
package:
  name: cadr_core

sources:
  - cadr_uinst_pkg.sv
  - cadr_arch_pkg.sv
  - cadr_alu.sv
  - cadr_sequencer.sv
  - cadr_debug_port.sv
  - cadr_control_store.sv
  - cadr_datapath.sv
  - cadr_top.sv
  - target: test
    files:
      - tb_cadr.sv
